//--- logic/mem_req_pkg.sv
////////////////////////////////////////////////////////////////////////////
// Memory request channel types: address, data and tag, the request kind,
// and the request and response structs
////////////////////////////////////////////////////////////////////////////

`default_nettype none

package mem_req_pkg;

    // Line address, counted in words
    typedef logic [31:0] addr_t;

    // One data word per request, since multi-line requests are not carried
    typedef logic [63:0] data_t;

    // Seven tag bits allow up to 128 requests in flight
    typedef logic [6:0] tag_t;

    typedef enum logic
    {
        REQ_READ  = 1'b0,
        REQ_WRITE = 1'b1
    } req_kind_t;

    // Request from the accelerator, passed on unchanged to memory.
    // The data field only matters for writes
    typedef struct packed
    {
        req_kind_t kind;
        tag_t      tag;
        addr_t     addr;
        data_t     data;
    } mem_req_t;

    // Read data is zero in a write response
    typedef struct packed
    {
        req_kind_t kind;
        tag_t      tag;
        data_t     data;
    } mem_rsp_t;

endpackage

`default_nettype wire

//--- logic/wro_cfg_pkg.sv
////////////////////////////////////////////////////////////////////////////
// Configuration and event structs of the write-read ordering shim
////////////////////////////////////////////////////////////////////////////

`default_nettype none

package wro_cfg_pkg;

    // Configuration input of the shim.
    // With the enable bit clear, requests pass without conflict checks
    typedef struct packed
    {
        logic enable_ordering;
    } wro_csr_t;

    // Event output of the shim
    typedef struct packed
    {
        // Cycles in which a valid head request was held back by a conflict
        logic [31:0] conflict_stalls;
    } wro_events_t;

endpackage

`default_nettype wire

//--- logic/credit_fifo.sv
////////////////////////////////////////////////////////////////////////////
// credit_fifo: circular buffer with a type parameter for its payload,
// flow controlled by the callers' credits
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

module credit_fifo
#(
    parameter type T = logic,
    parameter int DEPTH = 8
)
(
    input  wire logic clk,
    input  wire logic rst,

    input  wire logic push,
    input  wire T     push_data,

    // Pop removes the head at the same clock edge
    input  wire logic pop,

    output logic      head_valid,
    output T          head_data
);

    localparam int PTR_BITS = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_BITS = $clog2(DEPTH + 1);

    T mem [DEPTH];

    logic [PTR_BITS-1:0] wr_ptr;
    logic [PTR_BITS-1:0] rd_ptr;
    logic [CNT_BITS-1:0] count;

    // Entry storage, written at the tail pointer
    always_ff @(posedge clk)
    begin
        if (push)
        begin
            mem[wr_ptr] <= push_data;
        end
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            // Pointers wrap at DEPTH, which need not be a power of two
            if (push)
            begin
                wr_ptr <= (wr_ptr == PTR_BITS'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end

            if (pop)
            begin
                rd_ptr <= (rd_ptr == PTR_BITS'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end

            // Callers never push while full, so count stays within DEPTH
            count <= count + CNT_BITS'(push) - CNT_BITS'(pop);
        end
    end

    // A pushed entry shows up at the head on the cycle after its write
    assign head_valid = (count != '0);
    assign head_data  = mem[rd_ptr];

endmodule

`default_nettype wire

//--- logic/wro_hash_filter.sv
////////////////////////////////////////////////////////////////////////////
// wro_hash_filter: outstanding read and write counts per address hash
// bucket, and the conflict decision for the request at the buffer head
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

module wro_hash_filter
#(
    parameter int HASH_BITS = 6
)
(
    input  wire logic                  clk,
    input  wire logic                  rst,

    // Head request being checked; it is also the one that issues
    input  wire logic [HASH_BITS-1:0]  check_hash,
    input  wire mem_req_pkg::req_kind_t check_kind,
    input  wire logic                  issue,

    // Completion from memory, looked up in the tag table
    input  wire logic                  retire,
    input  wire logic [HASH_BITS-1:0]  retire_hash,
    input  wire mem_req_pkg::req_kind_t retire_kind,

    output logic                       conflict
);

    localparam int NUM_BUCKETS = 2 ** HASH_BITS;

    // One extra bit over the tag so a bucket can hold every tag at once
    localparam int CNT_BITS = $bits(mem_req_pkg::tag_t) + 1;

    logic [CNT_BITS-1:0] wr_cnt [NUM_BUCKETS];
    logic [CNT_BITS-1:0] rd_cnt [NUM_BUCKETS];

    logic issue_wr;
    logic issue_rd;
    logic retire_wr;
    logic retire_rd;

    assign issue_wr  = issue && (check_kind == mem_req_pkg::REQ_WRITE);
    assign issue_rd  = issue && (check_kind == mem_req_pkg::REQ_READ);
    assign retire_wr = retire && (retire_kind == mem_req_pkg::REQ_WRITE);
    assign retire_rd = retire && (retire_kind == mem_req_pkg::REQ_READ);

    // Issue and retire may hit the same bucket in one cycle and cancel out
    always_ff @(posedge clk)
    begin
        for (int i = 0; i < NUM_BUCKETS; i++)
        begin
            if (rst)
            begin
                wr_cnt[i] <= '0;
                rd_cnt[i] <= '0;
            end
            else
            begin
                wr_cnt[i] <= wr_cnt[i]
                    + CNT_BITS'(issue_wr && (check_hash == HASH_BITS'(i)))
                    - CNT_BITS'(retire_wr && (retire_hash == HASH_BITS'(i)));
                rd_cnt[i] <= rd_cnt[i]
                    + CNT_BITS'(issue_rd && (check_hash == HASH_BITS'(i)))
                    - CNT_BITS'(retire_rd && (retire_hash == HASH_BITS'(i)));
            end
        end
    end

    // A write waits for everything in its bucket, which keeps writes in
    // order. A read only waits for writes that may share its address
    always_comb
    begin
        if (check_kind == mem_req_pkg::REQ_WRITE)
        begin
            conflict = (wr_cnt[check_hash] != '0) || (rd_cnt[check_hash] != '0);
        end
        else
        begin
            conflict = (wr_cnt[check_hash] != '0);
        end
    end

endmodule

`default_nettype wire

//--- logic/wro_order_pipe.sv
////////////////////////////////////////////////////////////////////////////
// wro_order_pipe: request buffer, conflict gated issue with memory
// credits, stall event count, tag-to-hash table and the response path
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

module wro_order_pipe
#(
    parameter int HASH_BITS       = 6,
    parameter int REQ_DEPTH       = 8,
    parameter int MAX_ACTIVE_REQS = 128
)
(
    input  wire logic                     clk,
    input  wire logic                     rst,

    // Accelerator side
    input  wire logic                     afu_req_valid,
    input  wire mem_req_pkg::mem_req_t    afu_req,
    output logic                          afu_req_credit,
    output logic                          afu_rsp_valid,
    output mem_req_pkg::mem_rsp_t         afu_rsp,
    input  wire logic                     afu_rsp_credit,

    // Memory side
    output logic                          fiu_req_valid,
    output mem_req_pkg::mem_req_t         fiu_req,
    input  wire logic                     fiu_req_credit,
    input  wire logic                     fiu_rsp_valid,
    input  wire mem_req_pkg::mem_rsp_t    fiu_rsp,

    input  wire wro_cfg_pkg::wro_csr_t    csrs,
    output wro_cfg_pkg::wro_events_t      events
);

    localparam int TAG_IDX_BITS = $clog2(MAX_ACTIVE_REQS);
    localparam int CREDIT_BITS  = $clog2(MAX_ACTIVE_REQS) + 1;
    localparam int ADDR_BITS    = $bits(mem_req_pkg::addr_t);

    logic                   req_head_valid;
    mem_req_pkg::mem_req_t  req_head;
    logic [HASH_BITS-1:0]   head_hash;
    logic                   conflict;
    logic                   eligible;
    logic                   issue;
    logic [CREDIT_BITS-1:0] fiu_credits;

    logic                   rsp_head_valid;
    mem_req_pkg::mem_rsp_t  rsp_head;
    logic                   deliver;
    logic [CREDIT_BITS-1:0] afu_credits;

    // Tag table, written at issue and read when the response comes back
    logic [HASH_BITS-1:0]   tag_hash [MAX_ACTIVE_REQS];
    mem_req_pkg::req_kind_t tag_kind [MAX_ACTIVE_REQS];

    // The accelerator's credits keep this buffer from overflowing
    credit_fifo
    #(
        .T(mem_req_pkg::mem_req_t),
        .DEPTH(REQ_DEPTH)
    )
    req_fifo
    (
        .clk,
        .rst,
        .push(afu_req_valid),
        .push_data(afu_req),
        .pop(issue),
        .head_valid(req_head_valid),
        .head_data(req_head)
    );

    // Fold the head address into the bucket index with XOR
    always_comb
    begin
        head_hash = '0;
        for (int i = 0; i < ADDR_BITS; i += HASH_BITS)
        begin
            head_hash ^= HASH_BITS'(req_head.addr >> i);
        end
    end

    wro_hash_filter
    #(
        .HASH_BITS(HASH_BITS)
    )
    filter
    (
        .clk,
        .rst,
        .check_hash(head_hash),
        .check_kind(req_head.kind),
        .issue,
        .retire(fiu_rsp_valid),
        .retire_hash(tag_hash[fiu_rsp.tag[TAG_IDX_BITS-1:0]]),
        .retire_kind(tag_kind[fiu_rsp.tag[TAG_IDX_BITS-1:0]]),
        .conflict
    );

    // Ordering off lets every head through regardless of the filter
    assign eligible = req_head_valid && (!csrs.enable_ordering || !conflict);
    assign issue    = eligible && (fiu_credits != '0);

    // The freed buffer slot goes back to the accelerator right away
    assign afu_req_credit = issue;

    always_ff @(posedge clk)
    begin
        if (issue)
        begin
            tag_hash[req_head.tag[TAG_IDX_BITS-1:0]] <= head_hash;
            tag_kind[req_head.tag[TAG_IDX_BITS-1:0]] <= req_head.kind;
        end
    end

    // The memory can complete in any order, so no flow control here.
    // MAX_ACTIVE_REQS entries hold every response that can be in flight
    credit_fifo
    #(
        .T(mem_req_pkg::mem_rsp_t),
        .DEPTH(MAX_ACTIVE_REQS)
    )
    rsp_fifo
    (
        .clk,
        .rst,
        .push(fiu_rsp_valid),
        .push_data(fiu_rsp),
        .pop(deliver),
        .head_valid(rsp_head_valid),
        .head_data(rsp_head)
    );

    assign deliver = rsp_head_valid && (afu_credits != '0);

    // Payload registers follow the buffer heads every cycle
    always_ff @(posedge clk)
    begin
        fiu_req <= req_head;
        afu_rsp <= rsp_head;
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            fiu_req_valid          <= 1'b0;
            afu_rsp_valid          <= 1'b0;
            fiu_credits            <= '0;
            afu_credits            <= '0;
            events.conflict_stalls <= '0;
        end
        else
        begin
            fiu_req_valid <= issue;
            afu_rsp_valid <= deliver;
            fiu_credits   <= fiu_credits + CREDIT_BITS'(fiu_req_credit)
                           - CREDIT_BITS'(issue);
            afu_credits   <= afu_credits + CREDIT_BITS'(afu_rsp_credit)
                           - CREDIT_BITS'(deliver);

            // Waiting for a memory credit is back-pressure and not counted
            if (req_head_valid && csrs.enable_ordering && conflict)
            begin
                events.conflict_stalls <= events.conflict_stalls + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

//--- logic/wro_shim.sv
////////////////////////////////////////////////////////////////////////////
// wro_shim: top level of the ordering shim, registers the memory side's
// reset and holds the ordering pipeline
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

module wro_shim
#(
    parameter int HASH_BITS       = 6,
    parameter int REQ_DEPTH       = 8,
    parameter int MAX_ACTIVE_REQS = 128
)
(
    input  wire logic                     clk,
    input  wire logic                     fiu_rst,

    input  wire logic                     afu_req_valid,
    input  wire mem_req_pkg::mem_req_t    afu_req,
    output logic                          afu_req_credit,
    output logic                          afu_rsp_valid,
    output mem_req_pkg::mem_rsp_t         afu_rsp,
    input  wire logic                     afu_rsp_credit,

    output logic                          fiu_req_valid,
    output mem_req_pkg::mem_req_t         fiu_req,
    input  wire logic                     fiu_req_credit,
    input  wire logic                     fiu_rsp_valid,
    input  wire mem_req_pkg::mem_rsp_t    fiu_rsp,

    input  wire wro_cfg_pkg::wro_csr_t    csrs,
    output wro_cfg_pkg::wro_events_t      events
);

    logic rst;

    // Reset comes from the memory side. One register stage eases timing,
    // so the shim leaves reset one cycle after fiu_rst falls
    always_ff @(posedge clk)
    begin
        rst <= fiu_rst;
    end

    wro_order_pipe
    #(
        .HASH_BITS(HASH_BITS),
        .REQ_DEPTH(REQ_DEPTH),
        .MAX_ACTIVE_REQS(MAX_ACTIVE_REQS)
    )
    pipe
    (
        .clk,
        .rst,
        .afu_req_valid,
        .afu_req,
        .afu_req_credit,
        .afu_rsp_valid,
        .afu_rsp,
        .afu_rsp_credit,
        .fiu_req_valid,
        .fiu_req,
        .fiu_req_credit,
        .fiu_rsp_valid,
        .fiu_rsp,
        .csrs,
        .events
    );

endmodule

`default_nettype wire

//--- tests/wro_checker.sv
////////////////////////////////////////////////////////////////////////////
// wro_checker: watches the shim's ports, keeps the reference memory and
// request order, checks credits, data, tags and the stall event count
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

module wro_checker
#(
    parameter int REQ_DEPTH = 8
)
(
    input  wire logic                     clk,
    input  wire logic                     fiu_rst,

    input  wire logic                     afu_req_valid,
    input  wire mem_req_pkg::mem_req_t    afu_req,
    input  wire logic                     afu_req_credit,
    input  wire logic                     afu_rsp_valid,
    input  wire mem_req_pkg::mem_rsp_t    afu_rsp,
    input  wire logic                     afu_rsp_credit,

    input  wire logic                     fiu_req_valid,
    input  wire mem_req_pkg::mem_req_t    fiu_req,
    input  wire logic                     fiu_req_credit,
    input  wire logic                     fiu_rsp_valid,
    input  wire mem_req_pkg::mem_rsp_t    fiu_rsp,

    input  wire wro_cfg_pkg::wro_csr_t    csrs,
    input  wire wro_cfg_pkg::wro_events_t events,

    // Test control from the testbench
    input  wire logic [8*16-1:0]          test_name,
    input  wire logic                     check_data,
    input  wire logic [1:0]               expect_events,
    input  wire logic                     test_end,

    output int                            errors,
    output int                            checks
);

    // Accelerator requests in issue order, matched against the memory side
    mem_req_pkg::mem_req_t sent_q [$];

    // Memory as the accelerator expects it, and as the memory side built it
    mem_req_pkg::data_t ref_mem [64];
    mem_req_pkg::data_t mirror [64];

    // Per tag state of requests in flight
    logic                   busy [128];
    mem_req_pkg::req_kind_t busy_kind [128];
    mem_req_pkg::data_t     exp_rd [128];
    mem_req_pkg::addr_t     fiu_addr [128];
    mem_req_pkg::data_t     fiu_data [128];

    int fiu_granted;
    int fiu_used;
    int rsp_granted;
    int rsp_used;
    int acc_credits;

    // Each word starts out different, so a missed write shows up
    function automatic mem_req_pkg::data_t fill_word(int a);
        return {~32'(a), 32'(a)};
    endfunction

    task automatic report_value(input string what, input logic [127:0] exp,
                                input logic [127:0] act);
        errors++;
        $display("ERROR %0s %0s: expected %0h, actual %0h", test_name, what, exp, act);
    endtask

    task automatic report_fault(input string msg);
        errors++;
        $display("%0s: %0s", test_name, msg);
    endtask

    task automatic clear_state();
        sent_q.delete();
        fiu_granted = 0;
        fiu_used    = 0;
        rsp_granted = 0;
        rsp_used    = 0;
        acc_credits = REQ_DEPTH;
        for (int k = 0; k < 128; k++)
        begin
            busy[k] = 1'b0;
        end
        for (int k = 0; k < 64; k++)
        begin
            ref_mem[k] = fill_word(k);
            mirror[k]  = fill_word(k);
        end
    endtask

    // Running totals; a valid may never outrun the credits behind it
    task automatic check_credits();
        fiu_granted += int'(fiu_req_credit);
        fiu_used    += int'(fiu_req_valid);
        rsp_granted += int'(afu_rsp_credit);
        rsp_used    += int'(afu_rsp_valid);
        acc_credits += int'(afu_req_credit) - int'(afu_req_valid);
        if (fiu_used > fiu_granted)
        begin
            report_fault("memory request sent without a memory credit");
        end
        if (rsp_used > rsp_granted)
        begin
            report_fault("response delivered without an accelerator credit");
        end
        if (acc_credits > REQ_DEPTH)
        begin
            report_fault("request credits returned beyond the request buffer depth");
        end
    endtask

    // The reference applies writes in accelerator issue order
    task automatic track_request();
        sent_q.push_back(afu_req);
        if (busy[afu_req.tag])
        begin
            report_fault($sformatf("tag %0d reused while in flight", afu_req.tag));
        end
        busy[afu_req.tag]      = 1'b1;
        busy_kind[afu_req.tag] = afu_req.kind;
        if (afu_req.kind == mem_req_pkg::REQ_WRITE)
        begin
            ref_mem[afu_req.addr[5:0]] = afu_req.data;
        end
        else
        begin
            exp_rd[afu_req.tag] = ref_mem[afu_req.addr[5:0]];
        end
    endtask

    task automatic match_memory_request();
        mem_req_pkg::mem_req_t exp_req;
        if (sent_q.size() == 0)
        begin
            report_fault("memory request with no accelerator request pending");
        end
        else
        begin
            exp_req = sent_q.pop_front();
            checks++;
            if (fiu_req != exp_req)
            begin
                report_value("memory request", exp_req, fiu_req);
            end
        end
        fiu_addr[fiu_req.tag] = fiu_req.addr;
        fiu_data[fiu_req.tag] = fiu_req.data;
    endtask

    task automatic match_response();
        checks++;
        if (!busy[afu_rsp.tag])
        begin
            report_fault($sformatf("response for tag %0d, not in flight", afu_rsp.tag));
        end
        else if (afu_rsp.kind != busy_kind[afu_rsp.tag])
        begin
            report_value("response kind", busy_kind[afu_rsp.tag], afu_rsp.kind);
        end
        else if (check_data && csrs.enable_ordering && afu_rsp.kind == mem_req_pkg::REQ_READ)
        begin
            if (afu_rsp.data != exp_rd[afu_rsp.tag])
            begin
                report_value("read data", exp_rd[afu_rsp.tag], afu_rsp.data);
            end
        end
        busy[afu_rsp.tag] = 1'b0;
    endtask

    // Drained state at the end of a test
    task automatic finish_checks();
        for (int k = 0; k < 128; k++)
        begin
            if (busy[k])
            begin
                report_fault($sformatf("tag %0d never received a response", k));
            end
        end
        if (sent_q.size() != 0)
        begin
            report_fault($sformatf("%0d requests never reached memory", sent_q.size()));
        end
        if (check_data && csrs.enable_ordering)
        begin
            for (int k = 0; k < 64; k++)
            begin
                checks++;
                if (mirror[k] != ref_mem[k])
                begin
                    report_value($sformatf("memory word %0d", k), ref_mem[k], mirror[k]);
                end
            end
        end
        if (expect_events == 2'd1)
        begin
            checks++;
            if (events.conflict_stalls != 32'd0)
            begin
                report_value("conflict stalls", 32'd0, events.conflict_stalls);
            end
        end
        else if (expect_events == 2'd2)
        begin
            checks++;
            if (events.conflict_stalls == 32'd0)
            begin
                report_fault("no conflict stall counted on writes to one address");
            end
        end
    endtask

    initial
    begin
        errors = 0;
        checks = 0;
    end

    always @(posedge clk)
    begin
        if (fiu_rst)
        begin
            clear_state();
        end
        else
        begin
            check_credits();
            if (afu_req_valid)
            begin
                track_request();
            end
            if (fiu_req_valid)
            begin
                match_memory_request();
            end
            // Memory applies writes as they complete, mirror that order
            if (fiu_rsp_valid && fiu_rsp.kind == mem_req_pkg::REQ_WRITE)
            begin
                mirror[fiu_addr[fiu_rsp.tag][5:0]] = fiu_data[fiu_rsp.tag];
            end
            if (afu_rsp_valid)
            begin
                match_response();
            end
            if (test_end)
            begin
                finish_checks();
            end
        end
    end

endmodule

`default_nettype wire

//--- tests/wro_tb.sv
////////////////////////////////////////////////////////////////////////////
// wro_tb: clock and reset, random accelerator traffic, a memory model
// that completes out of order, and the sequence of tests
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

module wro_tb;

    localparam int REQ_DEPTH  = 8;
    localparam int MAX_FLIGHT = 32;
    localparam int MEM_SLOTS  = 16;
    localparam int TIMEOUT    = 20000;

    logic                     clk;
    logic                     fiu_rst;
    logic                     afu_req_valid;
    mem_req_pkg::mem_req_t    afu_req;
    logic                     afu_req_credit;
    logic                     afu_rsp_valid;
    mem_req_pkg::mem_rsp_t    afu_rsp;
    logic                     afu_rsp_credit;
    logic                     fiu_req_valid;
    mem_req_pkg::mem_req_t    fiu_req;
    logic                     fiu_req_credit;
    logic                     fiu_rsp_valid;
    mem_req_pkg::mem_rsp_t    fiu_rsp;
    wro_cfg_pkg::wro_csr_t    csrs;
    wro_cfg_pkg::wro_events_t events;

    logic [8*16-1:0] test_name;
    logic            check_data;
    logic [1:0]      expect_events;
    logic            test_end;
    int              errors;
    int              checks;

    integer seed;

    // Traffic control: mode 0 mixed, 1 distinct addresses, 2 one address
    // written over and over, 3 mostly writes
    logic running;
    int   mode;
    int   credit_pct;
    int   to_send;
    int   sent;
    int   done;
    int   in_flight;
    int   acc_credits;
    int   rsp_credits_out;
    int   next_tag;
    logic tag_busy [128];

    // Memory model with a small pool of request slots
    mem_req_pkg::data_t    mem_words [64];
    mem_req_pkg::mem_req_t pend_req [MEM_SLOTS];
    int                    pend_delay [MEM_SLOTS];
    int                    pend_count;
    int                    mem_credits_out;

    int tests_run;
    int tests_failed;

    wro_shim dut
    (
        .clk, .fiu_rst,
        .afu_req_valid, .afu_req, .afu_req_credit,
        .afu_rsp_valid, .afu_rsp, .afu_rsp_credit,
        .fiu_req_valid, .fiu_req, .fiu_req_credit,
        .fiu_rsp_valid, .fiu_rsp,
        .csrs, .events
    );

    wro_checker #(.REQ_DEPTH(REQ_DEPTH)) chk
    (
        .clk, .fiu_rst,
        .afu_req_valid, .afu_req, .afu_req_credit,
        .afu_rsp_valid, .afu_rsp, .afu_rsp_credit,
        .fiu_req_valid, .fiu_req, .fiu_req_credit,
        .fiu_rsp_valid, .fiu_rsp,
        .csrs, .events,
        .test_name, .check_data, .expect_events, .test_end,
        .errors, .checks
    );

    initial
    begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic mem_req_pkg::data_t fill_word(int a);
        return {~32'(a), 32'(a)};
    endfunction

    function automatic logic chance(int percent);
        return ($unsigned($random(seed)) % 100) < percent;
    endfunction

    function automatic int free_tag();
        int t;
        for (int k = 0; k < 128; k++)
        begin
            t = (next_tag + k) % 128;
            if (!tag_busy[t])
            begin
                return t;
            end
        end
        return 0;
    endfunction

    task automatic clear_models();
        afu_req_valid   <= 1'b0;
        afu_rsp_credit  <= 1'b0;
        fiu_req_credit  <= 1'b0;
        fiu_rsp_valid   <= 1'b0;
        sent            = 0;
        done            = 0;
        in_flight       = 0;
        next_tag        = 0;
        acc_credits     = REQ_DEPTH;
        rsp_credits_out = 0;
        pend_count      = 0;
        mem_credits_out = 0;
        for (int k = 0; k < 128; k++)
        begin
            tag_busy[k] = 1'b0;
        end
        for (int k = 0; k < 64; k++)
        begin
            mem_words[k] = fill_word(k);
        end
    endtask

    // Accelerator: spends request credits and grants response credits
    task automatic accel_step();
        mem_req_pkg::mem_req_t req;
        int                    slot;
        afu_req_valid  <= 1'b0;
        afu_rsp_credit <= 1'b0;
        acc_credits += int'(afu_req_credit);
        if (afu_rsp_valid)
        begin
            tag_busy[afu_rsp.tag] = 1'b0;
            rsp_credits_out--;
            in_flight--;
            done++;
        end
        if (running && sent < to_send && acc_credits > 0 && in_flight < MAX_FLIGHT
            && chance(70))
        begin
            slot     = free_tag();
            next_tag = slot + 1;
            req.tag  = mem_req_pkg::tag_t'(slot);
            req.data = {$random(seed), $random(seed)};
            case (mode)
                1: req.addr = mem_req_pkg::addr_t'(sent);
                2: req.addr = 32'd5;
                default: req.addr = $unsigned($random(seed)) % 8;
            endcase
            // Only writes hit the single address, mode 3 leans to writes
            if (mode == 2 || chance((mode == 3) ? 80 : 50))
            begin
                req.kind = mem_req_pkg::REQ_WRITE;
            end
            else
            begin
                req.kind = mem_req_pkg::REQ_READ;
            end
            afu_req_valid <= 1'b1;
            afu_req       <= req;
            tag_busy[slot] = 1'b1;
            acc_credits--;
            in_flight++;
            sent++;
        end
        if (running && rsp_credits_out < 4 && chance(credit_pct))
        begin
            afu_rsp_credit <= 1'b1;
            rsp_credits_out++;
        end
    endtask

    // Memory: random delays, picks any ready request, so completion is
    // out of order. Writes land and reads sample at completion
    task automatic memory_step();
        mem_req_pkg::mem_rsp_t rsp;
        int                    start;
        int                    idx;
        int                    j;
        fiu_rsp_valid  <= 1'b0;
        fiu_req_credit <= 1'b0;
        for (int k = 0; k < pend_count; k++)
        begin
            if (pend_delay[k] > 0)
            begin
                pend_delay[k]--;
            end
        end
        if (fiu_req_valid)
        begin
            pend_req[pend_count]   = fiu_req;
            pend_delay[pend_count] = 1 + $unsigned($random(seed)) % 8;
            pend_count++;
            mem_credits_out--;
        end
        idx = -1;
        if (pend_count > 0)
        begin
            start = $unsigned($random(seed)) % pend_count;
            for (int k = 0; k < pend_count; k++)
            begin
                j = (start + k) % pend_count;
                if (idx < 0 && pend_delay[j] == 0)
                begin
                    idx = j;
                end
            end
        end
        if (idx >= 0)
        begin
            rsp.kind = pend_req[idx].kind;
            rsp.tag  = pend_req[idx].tag;
            rsp.data = '0;
            if (pend_req[idx].kind == mem_req_pkg::REQ_WRITE)
            begin
                mem_words[pend_req[idx].addr[5:0]] = pend_req[idx].data;
            end
            else
            begin
                rsp.data = mem_words[pend_req[idx].addr[5:0]];
            end
            fiu_rsp_valid <= 1'b1;
            fiu_rsp       <= rsp;
            pend_count--;
            pend_req[idx]   = pend_req[pend_count];
            pend_delay[idx] = pend_delay[pend_count];
        end
        if (running && pend_count + mem_credits_out < MEM_SLOTS && chance(credit_pct))
        begin
            fiu_req_credit <= 1'b1;
            mem_credits_out++;
        end
    endtask

    // Both models in one block keep the random sequence fixed
    always @(posedge clk)
    begin
        if (fiu_rst)
        begin
            clear_models();
        end
        else
        begin
            accel_step();
            memory_step();
        end
    end

    task automatic apply_reset();
        @(posedge clk);
        fiu_rst <= 1'b1;
        repeat (5) @(posedge clk);
        fiu_rst <= 1'b0;
        // The shim leaves reset one cycle after fiu_rst falls
        repeat (2) @(posedge clk);
    endtask

    task automatic run_test(input logic [8*16-1:0] name, input logic ordering,
                            input int run_mode, input int count, input int rate,
                            input logic data_checks, input logic [1:0] event_rule);
        int cycles;
        int err_before;
        @(posedge clk);
        test_name            <= name;
        csrs.enable_ordering <= ordering;
        check_data           <= data_checks;
        expect_events        <= event_rule;
        mode                 <= run_mode;
        to_send              <= count;
        credit_pct           <= rate;
        apply_reset();
        err_before = errors;
        running <= 1'b1;
        cycles = 0;
        while (done < count)
        begin
            @(negedge clk);
            cycles++;
            if (cycles > TIMEOUT)
            begin
                $display("%0s: timed out with %0d of %0d responses", name, done, count);
                $display("test failed");
                $finish;
            end
        end
        @(posedge clk);
        running  <= 1'b0;
        test_end <= 1'b1;
        @(posedge clk);
        test_end <= 1'b0;
        @(posedge clk);
        tests_run++;
        if (errors == err_before)
        begin
            $display("PASS %0s", name);
        end
        else
        begin
            $display("FAIL %0s", name);
            tests_failed++;
        end
    endtask

    initial
    begin
        seed                 = 7;
        fiu_rst              = 1'b1;
        afu_req_valid        = 1'b0;
        afu_req              = '0;
        afu_rsp_credit       = 1'b0;
        fiu_req_credit       = 1'b0;
        fiu_rsp_valid        = 1'b0;
        fiu_rsp              = '0;
        csrs                 = '0;
        test_name            = '0;
        check_data           = 1'b0;
        expect_events        = 2'd0;
        test_end             = 1'b0;
        running              = 1'b0;
        mode                 = 0;
        credit_pct           = 50;
        to_send              = 0;
        tests_run            = 0;
        tests_failed         = 0;

        run_test("raw_order", 1'b1, 0, 200, 60, 1'b1, 2'd0);
        run_test("write_order", 1'b1, 3, 200, 60, 1'b1, 2'd0);
        run_test("unordered", 1'b0, 0, 200, 60, 1'b0, 2'd0);
        run_test("credits", 1'b1, 0, 150, 15, 1'b1, 2'd0);
        run_test("events_zero", 1'b1, 1, 32, 60, 1'b1, 2'd1);
        run_test("events_hot", 1'b1, 2, 16, 60, 1'b1, 2'd2);

        $display("summary: %0d tests, %0d failed, %0d checks, %0d errors",
                 tests_run, tests_failed, checks, errors);
        if (tests_failed == 0 && errors == 0)
        begin
            $display("test passed");
        end
        else
        begin
            $display("test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- flist.f
logic/mem_req_pkg.sv
logic/wro_cfg_pkg.sv
logic/credit_fifo.sv
logic/wro_hash_filter.sv
logic/wro_order_pipe.sv
logic/wro_shim.sv
tests/wro_checker.sv
tests/wro_tb.sv

//--- Bender.yml
package:
  name: wro_shim

sources:
  - logic/mem_req_pkg.sv
  - logic/wro_cfg_pkg.sv
  - logic/credit_fifo.sv
  - logic/wro_hash_filter.sv
  - logic/wro_order_pipe.sv
  - logic/wro_shim.sv
  - target: test
    files:
      - tests/wro_checker.sv
      - tests/wro_tb.sv
